// File: btb/btb.sv
// Direct-mapped branch target buffer
// Stores a tag, a target and a valid bit per row

`timescale 1ns/100ps

module btb (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [bpu_pkg::XLEN-1:0] lookup_pc_i,
  input  logic                     upd_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
  input  logic [bpu_pkg::XLEN-1:0] upd_target_i,
  output logic                     hit_o,
  output logic [bpu_pkg::XLEN-1:0] target_o
);

  import bpu_pkg::*;

  localparam int unsigned BtbRows = 1 << BTB_BITS;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Valid bits are control state and get the reset
  logic [BtbRows-1:0]   valid_q;
  // Tag and target rows, meaningless while the row is invalid
  logic [BTB_TAG_W-1:0] tag_q    [BtbRows];
  logic [XLEN-1:0]      target_q [BtbRows];

  // Index and tag fields of both PCs
  logic [BTB_BITS-1:0]  lkp_idx;
  logic [BTB_TAG_W-1:0] lkp_tag;
  logic [BTB_BITS-1:0]  upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;

  // Index sits right above the word offset, tag takes the rest
  assign lkp_idx = lookup_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign lkp_tag = lookup_pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign upd_idx = upd_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign upd_tag = upd_pc_i[XLEN-1:BTB_BITS+OFFSET];

  // ----------------------------------------
  // Update
  // ----------------------------------------

  // Flush invalidates every row and blocks a same-cycle update
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Payload rows
  always_ff @(posedge clk_i) begin
    if (upd_valid_i && !flush_i) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
    end
  end

  // ----------------------------------------
  // Lookup
  // ----------------------------------------

  // Hit needs a live row whose tag matches the fetch PC
  assign hit_o    = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);
  // Raw target, masked further up when there is no hit
  assign target_o = target_q[lkp_idx];

endmodule

// File: common/bpu_pkg.sv
// Shared definitions for the branch prediction unit
// Widths, table sizes, counter encoding and APB register map

package bpu_pkg;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------

  // PC and target width
  localparam int unsigned XLEN = 32;

  // Low PC bits skipped by every index, word-aligned instructions
  localparam int unsigned OFFSET = 2;

  // ----------------------------------------
  // Direction predictor
  // ----------------------------------------

  // Global history length, also log2 of the PHT rows
  localparam int unsigned HLEN = 4;

  // Two-bit saturating counter, MSB set means taken
  typedef enum logic [1:0] {
    SNT = 2'b00,
    WNT = 2'b01,
    WT  = 2'b10,
    ST  = 2'b11
  } c2b_t;

  // Counter value after reset and after a flush
  localparam c2b_t C2B_INIT = WNT;

  // ----------------------------------------
  // Branch target buffer
  // ----------------------------------------

  // log2 of the BTB rows
  localparam int unsigned BTB_BITS = 4;

  // Tag holds all PC bits above the index
  localparam int unsigned BTB_TAG_W = XLEN - BTB_BITS - OFFSET;

  // ----------------------------------------
  // APB register block
  // ----------------------------------------

  localparam int unsigned APB_AW = 4;

  // Statistics counter width, also the APB data width
  localparam int unsigned CNT_W = 32;

  // Register offsets
  localparam logic [APB_AW-1:0] REG_CTRL     = 'h0;
  localparam logic [APB_AW-1:0] REG_RES_CNT  = 'h4;
  localparam logic [APB_AW-1:0] REG_MISP_CNT = 'h8;

  // Bit positions inside CTRL
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned CTRL_FLUSH_BIT = 1;

endpackage

// File: gshare/gshare.sv
// Gshare direction predictor
// Global history XOR PC bits selects a two-bit saturating counter

`timescale 1ns/100ps

module gshare #(
  parameter int unsigned HLEN = bpu_pkg::HLEN
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [bpu_pkg::XLEN-1:0] curr_pc_i,
  input  logic                     res_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] res_pc_i,
  input  logic                     res_taken_i,
  output logic                     taken_o
);

  import bpu_pkg::*;

  localparam int unsigned PhtRows = 1 << HLEN;

  // Global outcome history, newest outcome in bit 0
  logic [HLEN-1:0] history_q;
  // Pattern history table
  c2b_t            pht_q [PhtRows];
  // Read index from fetch, write index from the resolution
  logic [HLEN-1:0] idx_rd;
  logic [HLEN-1:0] idx_wr;
  // Next value of the counter being trained
  c2b_t            cnt_next;

  // Hash the history with the word-address bits
  assign idx_rd = history_q ^ curr_pc_i[HLEN+OFFSET-1:OFFSET];
  assign idx_wr = history_q ^ res_pc_i[HLEN+OFFSET-1:OFFSET];

  // ----------------------------------------
  // Counter step, saturating at both ends
  // ----------------------------------------
  always_comb begin
    cnt_next = pht_q[idx_wr];
    case (pht_q[idx_wr])
      SNT:     cnt_next = res_taken_i ? WNT : SNT;
      WNT:     cnt_next = res_taken_i ? WT  : SNT;
      WT:      cnt_next = res_taken_i ? ST  : WNT;
      ST:      cnt_next = res_taken_i ? ST  : WT;
      default: cnt_next = C2B_INIT;
    endcase
  end

  // History shift register, flush wins over training
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      history_q <= '0;
    end else if (flush_i) begin
      history_q <= '0;
    end else if (res_valid_i) begin
      history_q <= {history_q[HLEN-2:0], res_taken_i};
    end
  end

  // Counter table, every row back to the initial state on flush
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PhtRows; i++) begin
        pht_q[i] <= C2B_INIT;
      end
    end else if (flush_i) begin
      for (int i = 0; i < PhtRows; i++) begin
        pht_q[i] <= C2B_INIT;
      end
    end else if (res_valid_i) begin
      pht_q[idx_wr] <= cnt_next;
    end
  end

  // Taken when the counter MSB is set
  assign taken_o = pht_q[idx_rd][1];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_bpu -f sources.f -o Vtb_bpu

./obj_dir/Vtb_bpu | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sources.f
common/bpu_pkg.sv
gshare/gshare.sv
btb/btb.sv
verilog/bpu_csr.sv
verilog/branch_predictor.sv
verilog/bpu_top.sv
tests/tb_bpu.sv

// File: tests/tb_bpu.sv
// Testbench for the branch prediction unit
// Directed tests checked against a model of history, counters and BTB

`timescale 1ns/100ps

module tb_bpu;

  import bpu_pkg::*;

  localparam int CLK_PERIOD = 4;
  // Limit far above the few hundred cycles the tests take
  localparam int TIMEOUT_NS = 5000 * CLK_PERIOD;
  localparam int PHT_ROWS   = 1 << HLEN;
  localparam int BTB_ROWS   = 1 << BTB_BITS;

  // DUT ports under the bpu_top port names
  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [APB_AW-1:0] paddr_i;
  logic [CNT_W-1:0]  pwdata_i;
  logic [CNT_W-1:0]  prdata_o;
  logic [XLEN-1:0]   fetch_pc_i;
  logic              pred_taken_o;
  logic [XLEN-1:0]   pred_target_o;
  logic              res_valid_i;
  logic [XLEN-1:0]   res_pc_i;
  logic [XLEN-1:0]   res_target_i;
  logic              res_taken_i;
  logic              res_mispredict_i;
  logic              flush_i;

  // Reference model state
  logic [HLEN-1:0]      m_hist;
  c2b_t                 m_pht [PHT_ROWS];
  logic [BTB_ROWS-1:0]  m_valid;
  logic [BTB_TAG_W-1:0] m_tag [BTB_ROWS];
  logic [XLEN-1:0]      m_tgt [BTB_ROWS];
  logic                 m_enable;
  logic [CNT_W-1:0]     m_res_cnt;
  logic [CNT_W-1:0]     m_misp_cnt;

  int seed   = 30;
  int checks = 0;
  int errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  bpu_top dut (.*);

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Reset and both flush sources leave the same state
  function automatic void clear_model();
    m_hist  = '0;
    m_valid = '0;
    for (int i = 0; i < PHT_ROWS; i++) begin
      m_pht[i] = C2B_INIT;
    end
  endfunction

  // Counter index uses the history from before the shift
  function automatic void train_model(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                                      input logic taken);
    logic [HLEN-1:0]     pi;
    logic [BTB_BITS-1:0] bi;
    pi = m_hist ^ pc[HLEN+OFFSET-1:OFFSET];
    bi = pc[BTB_BITS+OFFSET-1:OFFSET];
    if (taken && m_pht[pi] != ST) begin
      m_pht[pi] = c2b_t'(m_pht[pi] + 2'd1);
    end else if (!taken && m_pht[pi] != SNT) begin
      m_pht[pi] = c2b_t'(m_pht[pi] - 2'd1);
    end
    m_hist = {m_hist[HLEN-2:0], taken};
    // Only taken branches allocate a target
    if (taken) begin
      m_valid[bi] = 1'b1;
      m_tag[bi]   = pc[XLEN-1:BTB_BITS+OFFSET];
      m_tgt[bi]   = tgt;
    end
  endfunction

  // Taken needs enable, a tag hit and a counter at WT or above
  function automatic logic taken_in_model(input logic [XLEN-1:0] pc);
    logic [HLEN-1:0]     pi;
    logic [BTB_BITS-1:0] bi;
    pi = m_hist ^ pc[HLEN+OFFSET-1:OFFSET];
    bi = pc[BTB_BITS+OFFSET-1:OFFSET];
    return m_enable && m_valid[bi] && (m_tag[bi] == pc[XLEN-1:BTB_BITS+OFFSET])
           && (m_pht[pi] == WT || m_pht[pi] == ST);
  endfunction

  function automatic logic [XLEN-1:0] target_in_model(input logic [XLEN-1:0] pc);
    return taken_in_model(pc) ? m_tgt[pc[BTB_BITS+OFFSET-1:OFFSET]] : '0;
  endfunction

  // ----------------------------------------
  // Drivers and checkers
  // ----------------------------------------

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [CNT_W-1:0] data);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b1;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    // Write lands on the edge that ends the access phase
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [CNT_W-1:0] data);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b1;
    paddr_i   = addr;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    // prdata is combinational in the access phase
    #1;
    data      = prdata_o;
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic expect_reg(input logic [APB_AW-1:0] addr, input logic [CNT_W-1:0] exp,
                            input string what);
    logic [CNT_W-1:0] rd;
    apb_read(addr, rd);
    checks++;
    assert (rd === exp) else begin
      errors++;
      $display("mismatch at %0t: %s read 0x%08h, expected 0x%08h", $time, what, rd, exp);
    end
  endtask

  // CTRL write that keeps the model's enable and tables in step
  task automatic write_ctrl(input logic en, input logic flush);
    apb_write(REG_CTRL, {{(CNT_W-2){1'b0}}, flush, en});
    m_enable = en;
    if (flush) begin
      clear_model();
    end
  endtask

  // One-cycle resolution from execute
  task automatic resolve(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                         input logic taken, input logic misp);
    @(posedge clk_i);
    #1;
    res_valid_i      = 1'b1;
    res_pc_i         = pc;
    res_target_i     = tgt;
    res_taken_i      = taken;
    res_mispredict_i = misp;
    @(posedge clk_i);
    #1;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
    train_model(pc, tgt, taken);
    m_res_cnt  = m_res_cnt + 1;
    m_misp_cnt = m_misp_cnt + CNT_W'(misp);
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    clear_model();
  endtask

  task automatic check_prediction(input logic [XLEN-1:0] pc);
    logic            exp_taken;
    logic [XLEN-1:0] exp_target;
    @(posedge clk_i);
    #1;
    fetch_pc_i = pc;
    exp_taken  = taken_in_model(pc);
    exp_target = target_in_model(pc);
    #1;
    checks++;
    assert (pred_taken_o === exp_taken && pred_target_o === exp_target) else begin
      errors++;
      $display("mismatch at %0t: pc 0x%08h predicted %b/0x%08h, expected %b/0x%08h",
               $time, pc, pred_taken_o, pred_target_o, exp_taken, exp_target);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic registers_after_reset();
    expect_reg(REG_CTRL, 32'h0, "CTRL after reset");
    expect_reg(REG_RES_CNT, 32'h0, "RES_CNT after reset");
    expect_reg(REG_MISP_CNT, 32'h0, "MISP_CNT after reset");
    expect_reg(4'hC, 32'h0, "unmapped offset");
    write_ctrl(1'b1, 1'b0);
    expect_reg(REG_CTRL, 32'h1, "CTRL enable readback");
    // Flush bit never reads back
    write_ctrl(1'b1, 1'b1);
    expect_reg(REG_CTRL, 32'h1, "CTRL with flush written");
  endtask

  task automatic disabled_unit();
    write_ctrl(1'b0, 1'b1);
    repeat (6) begin
      resolve(32'h0000_1040, 32'h0000_2000, 1'b1, 1'b1);
      check_prediction(32'h0000_1040);
    end
    // Training went on while disabled
    write_ctrl(1'b1, 1'b0);
    check_prediction(32'h0000_1040);
  endtask

  task automatic direction_learning();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] tgt;
    logic [31:0]     r;
    logic            taken;
    write_ctrl(1'b1, 1'b1);
    // Walk one branch up to ST, then back down
    repeat (6) begin
      resolve(32'h0000_0100, 32'h0000_0800, 1'b1, !taken_in_model(32'h0000_0100));
      check_prediction(32'h0000_0100);
    end
    repeat (6) begin
      resolve(32'h0000_0100, 32'h0000_0800, 1'b0, taken_in_model(32'h0000_0100));
      check_prediction(32'h0000_0100);
    end
    // 64 PCs so both tables alias
    repeat (40) begin
      r     = $random(seed);
      pc    = 32'h0000_1000 | {24'b0, r[5:0], 2'b00};
      tgt   = $random(seed) & 32'hFFFF_FFFC;
      taken = r[8];
      resolve(pc, tgt, taken, taken != taken_in_model(pc));
      check_prediction(pc);
    end
  endtask

  task automatic btb_tagging();
    logic [XLEN-1:0] pc_b;
    // Same row and counter but one tag bit flipped
    pc_b = 32'h0000_2010 ^ (XLEN'(1) << (BTB_BITS + OFFSET));
    write_ctrl(1'b1, 1'b1);
    repeat (6) begin
      resolve(32'h0000_2010, 32'h0000_3000, 1'b1, 1'b0);
    end
    check_prediction(32'h0000_2010);
    check_prediction(pc_b);
  endtask

  task automatic flush_sources();
    // CSR flush drops what the BTB test trained
    write_ctrl(1'b1, 1'b1);
    check_prediction(32'h0000_2010);
    repeat (6) begin
      resolve(32'h0000_2010, 32'h0000_3000, 1'b1, 1'b0);
    end
    check_prediction(32'h0000_2010);
    pulse_flush();
    check_prediction(32'h0000_2010);
    // First resolution after flush trains a row the lookup no longer uses
    resolve(32'h0000_2010, 32'h0000_3000, 1'b1, 1'b0);
    check_prediction(32'h0000_2010);
  endtask

  task automatic statistics();
    expect_reg(REG_RES_CNT, m_res_cnt, "RES_CNT");
    expect_reg(REG_MISP_CNT, m_misp_cnt, "MISP_CNT");
    apb_write(REG_RES_CNT, 32'hFFFF_FFFF);
    apb_write(REG_MISP_CNT, 32'h0);
    m_res_cnt  = '0;
    m_misp_cnt = '0;
    expect_reg(REG_RES_CNT, 32'h0, "RES_CNT after clear");
    expect_reg(REG_MISP_CNT, 32'h0, "MISP_CNT after clear");
    resolve(32'h0000_0200, 32'h0000_0400, 1'b1, 1'b1);
    resolve(32'h0000_0204, 32'h0000_0400, 1'b0, 1'b0);
    resolve(32'h0000_0208, 32'h0000_0400, 1'b0, 1'b1);
    expect_reg(REG_RES_CNT, 32'd3, "RES_CNT after three resolutions");
    expect_reg(REG_MISP_CNT, 32'd2, "MISP_CNT after two mispredictions");
  endtask

  // ----------------------------------------
  // Run control
  // ----------------------------------------

  initial begin
    $timeformat(-9, 1, " ns", 10);
    rst_n_i          = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    pwrite_i         = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    fetch_pc_i       = '0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    flush_i          = 1'b0;
    m_enable         = 1'b0;
    m_res_cnt        = '0;
    m_misp_cnt       = '0;
    clear_model();
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    registers_after_reset();
    disabled_unit();
    direction_learning();
    btb_tagging();
    flush_sources();
    statistics();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule

// File: verilog/bpu_csr.sv
// APB register block of the branch predictor
// Enable bit, write-one flush and resolution statistics

`timescale 1ns/100ps

module bpu_csr (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // APB slave, zero wait states
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [bpu_pkg::APB_AW-1:0] paddr_i,
  input  logic [bpu_pkg::CNT_W-1:0]  pwdata_i,
  output logic [bpu_pkg::CNT_W-1:0]  prdata_o,
  // Resolutions from execute
  input  logic                       res_valid_i,
  input  logic                       res_mispredict_i,
  // Control towards the predictor
  output logic                       enable_o,
  output logic                       csr_flush_o
);

  import bpu_pkg::*;

  // Access phase strobes
  logic apb_wr;
  logic apb_rd;
  // Per-register write selects
  logic wr_ctrl;
  logic wr_res;
  logic wr_misp;

  // Register state
  logic             enable_q;
  logic             flush_q;
  logic [CNT_W-1:0] res_cnt_q;
  logic [CNT_W-1:0] misp_cnt_q;

  // ----------------------------------------
  // APB decode
  // ----------------------------------------

  // Access phase completes in the cycle penable is high
  assign apb_wr = psel_i & penable_i & pwrite_i;
  assign apb_rd = psel_i & penable_i & ~pwrite_i;

  assign wr_ctrl = apb_wr && (paddr_i == REG_CTRL);
  assign wr_res  = apb_wr && (paddr_i == REG_RES_CNT);
  assign wr_misp = apb_wr && (paddr_i == REG_MISP_CNT);

  // ----------------------------------------
  // Control register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      flush_q  <= 1'b0;
    end else begin
      // Flush bit is a single-cycle pulse, never stored
      flush_q <= wr_ctrl & pwdata_i[CTRL_FLUSH_BIT];
      if (wr_ctrl) begin
        enable_q <= pwdata_i[CTRL_EN_BIT];
      end
    end
  end

  // ----------------------------------------
  // Statistics counters
  // ----------------------------------------

  // A write to a counter clears it and beats the increment
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_cnt_q  <= '0;
      misp_cnt_q <= '0;
    end else begin
      if (wr_res) begin
        res_cnt_q <= '0;
      end else if (res_valid_i) begin
        res_cnt_q <= res_cnt_q + CNT_W'(1);
      end
      if (wr_misp) begin
        misp_cnt_q <= '0;
      end else if (res_valid_i && res_mispredict_i) begin
        misp_cnt_q <= misp_cnt_q + CNT_W'(1);
      end
    end
  end

  // Read data, only during the access phase of a read
  always_comb begin
    prdata_o = '0;
    if (apb_rd) begin
      case (paddr_i)
        REG_CTRL:     prdata_o[CTRL_EN_BIT] = enable_q;
        REG_RES_CNT:  prdata_o = res_cnt_q;
        REG_MISP_CNT: prdata_o = misp_cnt_q;
        default:      prdata_o = '0;
      endcase
    end
  end

  assign enable_o    = enable_q;
  assign csr_flush_o = flush_q;

endmodule

// File: verilog/bpu_top.sv
// Branch prediction unit top level
// APB register block next to the prediction datapath

`timescale 1ns/100ps

module bpu_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // APB slave
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [bpu_pkg::APB_AW-1:0] paddr_i,
  input  logic [bpu_pkg::CNT_W-1:0]  pwdata_i,
  output logic [bpu_pkg::CNT_W-1:0]  prdata_o,
  // Fetch
  input  logic [bpu_pkg::XLEN-1:0]   fetch_pc_i,
  output logic                       pred_taken_o,
  output logic [bpu_pkg::XLEN-1:0]   pred_target_o,
  // Resolution from execute
  input  logic                       res_valid_i,
  input  logic [bpu_pkg::XLEN-1:0]   res_pc_i,
  input  logic [bpu_pkg::XLEN-1:0]   res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  // Pipeline flush
  input  logic                       flush_i
);

  // CSR control towards the datapath
  logic enable;
  logic csr_flush;

  bpu_csr u_csr (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .psel_i           (psel_i),
    .penable_i        (penable_i),
    .pwrite_i         (pwrite_i),
    .paddr_i          (paddr_i),
    .pwdata_i         (pwdata_i),
    .prdata_o         (prdata_o),
    .res_valid_i      (res_valid_i),
    .res_mispredict_i (res_mispredict_i),
    .enable_o         (enable),
    .csr_flush_o      (csr_flush)
  );

  branch_predictor u_pred (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .csr_flush_i   (csr_flush),
    .enable_i      (enable),
    .fetch_pc_i    (fetch_pc_i),
    .res_valid_i   (res_valid_i),
    .res_pc_i      (res_pc_i),
    .res_target_i  (res_target_i),
    .res_taken_i   (res_taken_i),
    .pred_taken_o  (pred_taken_o),
    .pred_target_o (pred_target_o)
  );

endmodule

// File: verilog/branch_predictor.sv
// Prediction datapath
// Joins gshare direction, BTB hit and the enable bit into one prediction

`timescale 1ns/100ps

module branch_predictor (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic                     csr_flush_i,
  input  logic                     enable_i,
  input  logic [bpu_pkg::XLEN-1:0] fetch_pc_i,
  input  logic                     res_valid_i,
  input  logic [bpu_pkg::XLEN-1:0] res_pc_i,
  input  logic [bpu_pkg::XLEN-1:0] res_target_i,
  input  logic                     res_taken_i,
  output logic                     pred_taken_o,
  output logic [bpu_pkg::XLEN-1:0] pred_target_o
);

  import bpu_pkg::*;

  // Pipeline flush and CSR flush clear the same state
  logic            tbl_flush;
  logic            gs_taken;
  logic            btb_hit;
  logic [XLEN-1:0] btb_target;

  assign tbl_flush = flush_i | csr_flush_i;

  gshare u_gshare (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (tbl_flush),
    .curr_pc_i   (fetch_pc_i),
    .res_valid_i (res_valid_i),
    .res_pc_i    (res_pc_i),
    .res_taken_i (res_taken_i),
    .taken_o     (gs_taken)
  );

  // Only taken branches allocate a BTB row
  btb u_btb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (tbl_flush),
    .lookup_pc_i  (fetch_pc_i),
    .upd_valid_i  (res_valid_i & res_taken_i),
    .upd_pc_i     (res_pc_i),
    .upd_target_i (res_target_i),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Predict taken only with a known target
  assign pred_taken_o  = enable_i & btb_hit & gs_taken;
  assign pred_target_o = pred_taken_o ? btb_target : '0;

endmodule
